/* Makefile */
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module x25519_core_tb -f x25519_core.f -o x25519_core_sim
	./obj_dir/x25519_core_sim | tee sim.log
	@if grep -q "TEST FAILED" sim.log; then echo "Simulation failed"; exit 1; fi
	@if ! grep -q "TEST PASSED" sim.log; then echo "Simulation did not finish"; exit 1; fi

clean:
	rm -rf obj_dir sim.log

/* hw/x25519_addsub.sv */
`timescale 1ns/1ps
`default_nettype none

// Modular add and subtract in one registered stage
module x25519_addsub (
	input  wire                  clk,
	input  wire                  rst,
	input  wire                  go,
	input  x25519_pkg::regval_t  a,
	input  x25519_pkg::regval_t  b,
	input  x25519_pkg::xregid_t  dst0,
	input  x25519_pkg::xregid_t  dst1,
	x25519_retire_if.unit        retire
);

	import x25519_pkg::*;

	logic [256:0] sum;
	logic [256:0] sum_minus_p;
	logic [256:0] diff;
	regval_t      sum_mod;
	regval_t      diff_mod;

	always_comb begin
		// Sum of two reduced values fits in 256 bits
		sum         = {1'b0, a} + {1'b0, b};
		sum_minus_p = sum - {1'b0, FIELD_P};
		// Borrow means sum was already below p
		sum_mod     = sum_minus_p[256] ? sum[255:0] : sum_minus_p[255:0];

		// Difference, add p back on borrow
		diff        = {1'b0, a} - {1'b0, b};
		diff_mod    = diff[256] ? (diff[255:0] + FIELD_P) : diff[255:0];
	end

	always_ff @(posedge clk) begin
		if (rst)
			retire.valid <= 1'b0;
		else
			retire.valid <= go;
	end

	// Sum to dst0, difference to dst1
	always_ff @(posedge clk) begin
		if (go) begin
			retire.addr0 <= dst0;
			retire.addr1 <= dst1;
			retire.data0 <= sum_mod;
			retire.data1 <= diff_mod;
		end
	end

endmodule

`default_nettype wire

/* hw/x25519_core.sv */
`timescale 1ns/1ps
`default_nettype none

// Field register engine top level
module x25519_core (
	input  wire                     clk,
	input  wire                     rst,
	input  wire                     load_valid,
	input  x25519_pkg::xregid_t     load_addr,
	input  x25519_pkg::regval_t     load_data,
	input  wire                     dump_valid,
	input  x25519_pkg::xregid_t     dump_addr,
	output x25519_pkg::regval_t     dump_data,
	output logic                    dump_data_valid,
	input  wire                     cmd_valid,
	input  x25519_pkg::x25519_op_t  cmd_op,
	input  wire                     cmd_swap,
	input  x25519_pkg::xregid_t     cmd_src_a,
	input  x25519_pkg::xregid_t     cmd_src_b,
	input  x25519_pkg::xregid_t     cmd_dst0,
	input  x25519_pkg::xregid_t     cmd_dst1
);

	import x25519_pkg::*;

	////////////////////////////////////////
	// Internal wiring

	logic    rd_en;
	xregid_t rd_addr_a;
	xregid_t rd_addr_b;
	regval_t operand_a;
	regval_t operand_b;
	logic    operand_valid;
	logic    op_addsub_go;
	logic    op_swap_go;
	logic    exec_swap;
	xregid_t exec_dst0;
	xregid_t exec_dst1;

	// Result paths back to the register file
	x25519_retire_if retire_addsub ();
	x25519_retire_if retire_swap ();

	////////////////////////////////////////
	// Instances

	x25519_issue i_issue (
		.clk           (clk),
		.rst           (rst),
		.cmd_valid     (cmd_valid),
		.cmd_op        (cmd_op),
		.cmd_swap      (cmd_swap),
		.cmd_src_a     (cmd_src_a),
		.cmd_src_b     (cmd_src_b),
		.cmd_dst0      (cmd_dst0),
		.cmd_dst1      (cmd_dst1),
		.rd_en         (rd_en),
		.rd_addr_a     (rd_addr_a),
		.rd_addr_b     (rd_addr_b),
		.operand_valid (operand_valid),
		.op_addsub_go  (op_addsub_go),
		.op_swap_go    (op_swap_go),
		.exec_swap     (exec_swap),
		.exec_dst0     (exec_dst0),
		.exec_dst1     (exec_dst1)
	);

	x25519_regfile i_regfile (
		.clk             (clk),
		.rst             (rst),
		.load_valid      (load_valid),
		.load_addr       (load_addr),
		.load_data       (load_data),
		.retire_a        (retire_addsub),
		.retire_b        (retire_swap),
		.rd_en           (rd_en),
		.rd_addr_a       (rd_addr_a),
		.rd_addr_b       (rd_addr_b),
		.dump_valid      (dump_valid),
		.dump_addr       (dump_addr),
		.operand_a       (operand_a),
		.operand_b       (operand_b),
		.operand_valid   (operand_valid),
		.dump_data       (dump_data),
		.dump_data_valid (dump_data_valid)
	);

	x25519_addsub i_addsub (
		.clk    (clk),
		.rst    (rst),
		.go     (op_addsub_go),
		.a      (operand_a),
		.b      (operand_b),
		.dst0   (exec_dst0),
		.dst1   (exec_dst1),
		.retire (retire_addsub)
	);

	x25519_swap i_swap (
		.clk    (clk),
		.rst    (rst),
		.go     (op_swap_go),
		.swap   (exec_swap),
		.a      (operand_a),
		.b      (operand_b),
		.dst0   (exec_dst0),
		.dst1   (exec_dst1),
		.retire (retire_swap)
	);

endmodule

`default_nettype wire

/* hw/x25519_issue.sv */
`timescale 1ns/1ps
`default_nettype none

// Two-stage command pipeline in front of the register file
module x25519_issue (
	input  wire                     clk,
	input  wire                     rst,
	input  wire                     cmd_valid,
	input  x25519_pkg::x25519_op_t  cmd_op,
	input  wire                     cmd_swap,
	input  x25519_pkg::xregid_t     cmd_src_a,
	input  x25519_pkg::xregid_t     cmd_src_b,
	input  x25519_pkg::xregid_t     cmd_dst0,
	input  x25519_pkg::xregid_t     cmd_dst1,
	output logic                    rd_en,
	output x25519_pkg::xregid_t     rd_addr_a,
	output x25519_pkg::xregid_t     rd_addr_b,
	input  wire                     operand_valid,
	output logic                    op_addsub_go,
	output logic                    op_swap_go,
	output logic                    exec_swap,
	output x25519_pkg::xregid_t     exec_dst0,
	output x25519_pkg::xregid_t     exec_dst1
);

	import x25519_pkg::*;

	// Stage one holds the command
	logic       s1_valid;
	x25519_op_t s1_op;
	logic       s1_swap;
	xregid_t    s1_src_a;
	xregid_t    s1_src_b;
	xregid_t    s1_dst0;
	xregid_t    s1_dst1;

	// Stage two rides alongside the operand read
	logic       s2_valid;
	x25519_op_t s2_op;

	always_ff @(posedge clk) begin
		if (rst) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
		end else begin
			s1_valid <= cmd_valid;
			s2_valid <= s1_valid;
		end
	end

	always_ff @(posedge clk) begin
		s1_op     <= cmd_op;
		s1_swap   <= cmd_swap;
		s1_src_a  <= cmd_src_a;
		s1_src_b  <= cmd_src_b;
		s1_dst0   <= cmd_dst0;
		s1_dst1   <= cmd_dst1;
		s2_op     <= s1_op;
		exec_swap <= s1_swap;
		exec_dst0 <= s1_dst0;
		exec_dst1 <= s1_dst1;
	end

	// Read addresses straight from stage one
	assign rd_en     = s1_valid;
	assign rd_addr_a = s1_src_a;
	assign rd_addr_b = s1_src_b;

	// Dispatch to one unit when the operands arrive
	assign op_addsub_go = operand_valid && (s2_op == OP_ADDSUB);
	assign op_swap_go   = operand_valid && (s2_op == OP_SWAP);

	// Register file read latency must match stage two
	assert property (@(posedge clk) disable iff (rst) operand_valid == s2_valid);

endmodule

`default_nettype wire

/* hw/x25519_pkg.sv */
`default_nettype none

package x25519_pkg;

	////////////////////////////////////////
	// Basic types

	// Register number, 16 entries
	typedef logic [3:0] xregid_t;

	// One field element, reduced below p
	typedef logic [255:0] regval_t;

	// Command opcode
	typedef enum logic {
		OP_ADDSUB = 1'b0,
		OP_SWAP   = 1'b1
	} x25519_op_t;

	////////////////////////////////////////
	// Register map

	// Highest general purpose register
	localparam xregid_t REG_TEMP_LAST = 4'd11;

	// Read-only constants
	localparam xregid_t REG_ONE    = 4'd12;
	localparam xregid_t REG_ZERO   = 4'd13;
	localparam xregid_t REG_121665 = 4'd14;
	localparam xregid_t REG_D2     = 4'd15;

	////////////////////////////////////////
	// Constant values

	localparam regval_t VAL_ONE    = 256'd1;
	localparam regval_t VAL_ZERO   = 256'd0;
	localparam regval_t VAL_121665 = 256'd121665;
	// Twice the Edwards curve constant d
	localparam regval_t VAL_D2 =
		256'h2406d9dc_56dffce7_198e80f2_eef3d130_00e0149a_8283b156_ebd69b94_26b2f159;

	// Field modulus 2^255 - 19
	localparam regval_t FIELD_P =
		256'h7fffffff_ffffffff_ffffffff_ffffffff_ffffffff_ffffffff_ffffffff_ffffffed;

endpackage

`default_nettype wire

/* hw/x25519_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

// Two-write-port register file from two banks and a live value table
module x25519_regfile (
	input  wire                  clk,
	input  wire                  rst,
	input  wire                  load_valid,
	input  x25519_pkg::xregid_t  load_addr,
	input  x25519_pkg::regval_t  load_data,
	x25519_retire_if.rf          retire_a,
	x25519_retire_if.rf          retire_b,
	input  wire                  rd_en,
	input  x25519_pkg::xregid_t  rd_addr_a,
	input  x25519_pkg::xregid_t  rd_addr_b,
	input  wire                  dump_valid,
	input  x25519_pkg::xregid_t  dump_addr,
	output x25519_pkg::regval_t  operand_a,
	output x25519_pkg::regval_t  operand_b,
	output logic                 operand_valid,
	output x25519_pkg::regval_t  dump_data,
	output logic                 dump_data_valid
);

	import x25519_pkg::*;

	////////////////////////////////////////
	// Write arbitration

	logic    p0_wr_en;
	logic    p1_wr_en;
	xregid_t p0_wr_addr;
	xregid_t p1_wr_addr;
	regval_t p0_wr_data;
	regval_t p1_wr_data;

	always_comb begin
		p0_wr_en   = 1'b0;
		p1_wr_en   = 1'b0;
		p0_wr_addr = load_addr;
		p1_wr_addr = retire_a.addr1;
		p0_wr_data = load_data;
		p1_wr_data = retire_a.data1;

		// Retire takes both ports, addr0 on port 0 and addr1 on port 1
		if (retire_a.valid) begin
			p0_wr_en   = 1'b1;
			p1_wr_en   = 1'b1;
			p0_wr_addr = retire_a.addr0;
			p0_wr_data = retire_a.data0;
		end else if (retire_b.valid) begin
			p0_wr_en   = 1'b1;
			p1_wr_en   = 1'b1;
			p0_wr_addr = retire_b.addr0;
			p1_wr_addr = retire_b.addr1;
			p0_wr_data = retire_b.data0;
			p1_wr_data = retire_b.data1;
		end else if (load_valid) begin
			// Host load shares port 0
			p0_wr_en = 1'b1;
		end

		// Constant registers are read-only
		if (p0_wr_addr > REG_TEMP_LAST)
			p0_wr_en = 1'b0;
		if (p1_wr_addr > REG_TEMP_LAST)
			p1_wr_en = 1'b0;
	end

	////////////////////////////////////////
	// Banks

	regval_t b0_rd_a;
	regval_t b0_rd_b;
	regval_t b0_rd_d;
	regval_t b1_rd_a;
	regval_t b1_rd_b;
	regval_t b1_rd_d;

	x25519_regfile_bank i_bank0 (
		.clk      (clk),
		.wr_en    (p0_wr_en),
		.wr_addr  (p0_wr_addr),
		.wr_data  (p0_wr_data),
		.rd_addr0 (rd_addr_a),
		.rd_addr1 (rd_addr_b),
		.rd_addr2 (dump_addr),
		.rd_data0 (b0_rd_a),
		.rd_data1 (b0_rd_b),
		.rd_data2 (b0_rd_d)
	);

	x25519_regfile_bank i_bank1 (
		.clk      (clk),
		.wr_en    (p1_wr_en),
		.wr_addr  (p1_wr_addr),
		.wr_data  (p1_wr_data),
		.rd_addr0 (rd_addr_a),
		.rd_addr1 (rd_addr_b),
		.rd_addr2 (dump_addr),
		.rd_data0 (b1_rd_a),
		.rd_data1 (b1_rd_b),
		.rd_data2 (b1_rd_d)
	);

	////////////////////////////////////////
	// Live value table

	// One bit per register, set means bank 1 holds the newest value
	logic [15:0] lvt = '0;

	// Port 1 update comes second so it wins on a shared address
	always_ff @(posedge clk) begin
		if (p0_wr_en)
			lvt[p0_wr_addr] <= 1'b0;
		if (p1_wr_en)
			lvt[p1_wr_addr] <= 1'b1;
	end

	////////////////////////////////////////
	// Output registers

	always_ff @(posedge clk) begin
		// Operand fetch for the issue stage
		if (rd_en) begin
			operand_a <= lvt[rd_addr_a] ? b1_rd_a : b0_rd_a;
			operand_b <= lvt[rd_addr_b] ? b1_rd_b : b0_rd_b;
		end
		// Host readback on its own port
		if (dump_valid)
			dump_data <= lvt[dump_addr] ? b1_rd_d : b0_rd_d;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			operand_valid   <= 1'b0;
			dump_data_valid <= 1'b0;
		end else begin
			operand_valid   <= rd_en;
			dump_data_valid <= dump_valid;
		end
	end

	// Host must keep loads clear of retire cycles
	assert property (@(posedge clk) disable iff (rst)
		!(load_valid && (retire_a.valid || retire_b.valid)));

	// Units have equal latency, so retires never overlap
	assert property (@(posedge clk) disable iff (rst)
		!(retire_a.valid && retire_b.valid));

endmodule

`default_nettype wire

/* hw/x25519_regfile_bank.sv */
`timescale 1ns/1ps
`default_nettype none

// One bank: one write port, three async read ports
module x25519_regfile_bank (
	input  wire                  clk,
	input  wire                  wr_en,
	input  x25519_pkg::xregid_t  wr_addr,
	input  x25519_pkg::regval_t  wr_data,
	input  x25519_pkg::xregid_t  rd_addr0,
	input  x25519_pkg::xregid_t  rd_addr1,
	input  x25519_pkg::xregid_t  rd_addr2,
	output x25519_pkg::regval_t  rd_data0,
	output x25519_pkg::regval_t  rd_data1,
	output x25519_pkg::regval_t  rd_data2
);

	import x25519_pkg::*;

	////////////////////////////////////////
	// Storage

	// Small and wide, maps to distributed RAM
	regval_t mem [16];

	// General registers start at zero, top four hold the constants
	initial begin
		for (int i = 0; i <= int'(REG_TEMP_LAST); i++)
			mem[i] = VAL_ZERO;
		mem[REG_ONE]    = VAL_ONE;
		mem[REG_ZERO]   = VAL_ZERO;
		mem[REG_121665] = VAL_121665;
		mem[REG_D2]     = VAL_D2;
	end

	// Write on the clock
	always_ff @(posedge clk) begin
		if (wr_en)
			mem[wr_addr] <= wr_data;
	end

	// Reads are combinational
	assign rd_data0 = mem[rd_addr0];
	assign rd_data1 = mem[rd_addr1];
	assign rd_data2 = mem[rd_addr2];

endmodule

`default_nettype wire

/* hw/x25519_retire_if.sv */
`timescale 1ns/1ps
`default_nettype none

// Two-destination result from an execution unit
interface x25519_retire_if;

	import x25519_pkg::*;

	// Single-cycle strobe
	logic    valid;

	// First destination, written through bank port 0
	xregid_t addr0;
	regval_t data0;

	// Second destination, written through bank port 1
	xregid_t addr1;
	regval_t data1;

	// Execution unit side
	modport unit (
		output valid,
		output addr0,
		output addr1,
		output data0,
		output data1
	);

	// Register file side
	modport rf (
		input valid,
		input addr0,
		input addr1,
		input data0,
		input data1
	);

endinterface

`default_nettype wire

/* hw/x25519_swap.sv */
`timescale 1ns/1ps
`default_nettype none

// Conditional swap for the ladder step
module x25519_swap (
	input  wire                  clk,
	input  wire                  rst,
	input  wire                  go,
	input  wire                  swap,
	input  x25519_pkg::regval_t  a,
	input  x25519_pkg::regval_t  b,
	input  x25519_pkg::xregid_t  dst0,
	input  x25519_pkg::xregid_t  dst1,
	x25519_retire_if.unit        retire
);

	import x25519_pkg::*;

	// Same one-cycle latency as the adder
	always_ff @(posedge clk) begin
		if (rst)
			retire.valid <= 1'b0;
		else
			retire.valid <= go;
	end

	// Flag set sends b to dst0 and a to dst1
	always_ff @(posedge clk) begin
		if (go) begin
			retire.addr0 <= dst0;
			retire.addr1 <= dst1;
			retire.data0 <= swap ? b : a;
			retire.data1 <= swap ? a : b;
		end
	end

endmodule

`default_nettype wire

/* tests/x25519_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module x25519_core_tb;

	import x25519_pkg::*;

	localparam int N_ADDSUB = 40;
	localparam int N_SWAP   = 24;
	localparam int N_B2B    = 32;

	// Cycle budget: reset, dump sweeps, eight cycles per single case, then the burst
	localparam int RUN_CYCLES =
		10 + 16 + 24 + 8 + 8 * (N_ADDSUB + 5 + N_SWAP + 2) + 6 + N_B2B + 10 + 4;
	localparam int TIMEOUT_NS = (RUN_CYCLES + 200) * 40;

	// Field modulus and the 2d constant, derived independently of the DUT
	localparam regval_t P = (256'd1 << 255) - 256'd19;
	localparam regval_t D2_VAL =
		256'h2406d9dc_56dffce7_198e80f2_eef3d130_00e0149a_8283b156_ebd69b94_26b2f159;

	logic       clk = 1'b0;
	logic       rst;
	logic       load_valid;
	xregid_t    load_addr;
	regval_t    load_data;
	logic       dump_valid;
	xregid_t    dump_addr;
	regval_t    dump_data;
	logic       dump_data_valid;
	logic       cmd_valid;
	x25519_op_t cmd_op;
	logic       cmd_swap;
	xregid_t    cmd_src_a;
	xregid_t    cmd_src_b;
	xregid_t    cmd_dst0;
	xregid_t    cmd_dst1;

	// Reference state and pending writes, slot per cycle modulo 8
	regval_t    shadow [16];
	logic       pend_v [8];
	xregid_t    pend_a0 [8];
	regval_t    pend_d0 [8];
	xregid_t    pend_a1 [8];
	regval_t    pend_d1 [8];
	logic [2:0] now_slot = 3'd0;

	// Expected readback, delayed to meet the response
	regval_t exp_req = '0;
	regval_t exp_resp = '0;
	string   test_name = "";
	string   req_name = "";
	string   resp_name = "";
	int      checks = 0;
	int      val_errors = 0;
	int      proto_errors = 0;

	always #20 clk = ~clk;

	x25519_core i_x25519_core (
		.clk             (clk),
		.rst             (rst),
		.load_valid      (load_valid),
		.load_addr       (load_addr),
		.load_data       (load_data),
		.dump_valid      (dump_valid),
		.dump_addr       (dump_addr),
		.dump_data       (dump_data),
		.dump_data_valid (dump_data_valid),
		.cmd_valid       (cmd_valid),
		.cmd_op          (cmd_op),
		.cmd_swap        (cmd_swap),
		.cmd_src_a       (cmd_src_a),
		.cmd_src_b       (cmd_src_b),
		.cmd_dst0        (cmd_dst0),
		.cmd_dst1        (cmd_dst1)
	);

	always @(posedge clk) begin
		exp_resp  <= exp_req;
		resp_name <= req_name;
	end

	////////////////////////////////////////
	// Checks, sampled mid-cycle

	assert property (@(negedge clk) disable iff (rst) dump_data_valid |-> dump_data == exp_resp)
	else begin
		val_errors++;
		$display("** Error %s: expected %h, actual %h", resp_name, exp_resp, dump_data);
	end

	// Exactly one response per request, one cycle later
	assert property (@(negedge clk) disable iff (rst) dump_data_valid == $past(dump_valid))
	else begin
		proto_errors++;
		$display("Readback valid at %0t does not match the request one cycle earlier", $time);
	end

	initial begin
		#(TIMEOUT_NS);
		$display("Timeout: run did not finish within %0d ns", TIMEOUT_NS);
		$display("TEST FAILED");
		$finish;
	end

	////////////////////////////////////////
	// Reference model

	function automatic regval_t mod_add(regval_t a, regval_t b);
		logic [256:0] s;
		s = {1'b0, a} + {1'b0, b};
		if (s >= {1'b0, P})
			s = s - {1'b0, P};
		return s[255:0];
	endfunction

	function automatic regval_t mod_sub(regval_t a, regval_t b);
		if (a >= b)
			return a - b;
		// Wraps below zero, so the result is a + p - b
		return a + (P - b);
	endfunction

	// Uniform residue, redrawn until below p
	function automatic regval_t rand_val();
		regval_t v;
		do begin
			for (int i = 0; i < 8; i++)
				v[i*32 +: 32] = $urandom();
		end while (v >= P);
		return v;
	endfunction

	function automatic xregid_t pick_reg(int lo, int hi);
		return xregid_t'($urandom_range(hi, lo));
	endfunction

	// Constants and anything above 11 stay untouched
	function automatic void write_shadow(xregid_t a, regval_t d);
		if (a <= 4'd11)
			shadow[a] = d;
	endfunction

	task automatic schedule(logic [2:0] delay, xregid_t a0, regval_t d0, xregid_t a1, regval_t d1);
		logic [2:0] s;
		s = now_slot + delay;
		pend_v[s]  = 1'b1;
		pend_a0[s] = a0;
		pend_d0[s] = d0;
		pend_a1[s] = a1;
		pend_d1[s] = d1;
	endtask

	////////////////////////////////////////
	// Host driver

	// One clock, retire landed writes, strobes back to idle
	task automatic tick();
		@(posedge clk);
		now_slot = now_slot + 3'd1;
		if (pend_v[now_slot]) begin
			// Port 1 applied last, it wins on a shared address
			write_shadow(pend_a0[now_slot], pend_d0[now_slot]);
			write_shadow(pend_a1[now_slot], pend_d1[now_slot]);
			pend_v[now_slot] = 1'b0;
		end
		load_valid <= 1'b0;
		dump_valid <= 1'b0;
		cmd_valid  <= 1'b0;
	endtask

	task automatic idle(int n);
		repeat (n) tick();
	endtask

	task automatic load(xregid_t r, regval_t v);
		tick();
		load_valid <= 1'b1;
		load_addr  <= r;
		load_data  <= v;
		// Loads use port 0 only, 4'hf in the second slot is dropped
		schedule(3'd1, r, v, 4'hf, '0);
	endtask

	// Dump in the current cycle, no clock
	task automatic request_dump(xregid_t r);
		dump_valid <= 1'b1;
		dump_addr  <= r;
		exp_req    <= shadow[r];
		req_name   <= test_name;
		checks++;
	endtask

	task automatic dump(xregid_t r);
		tick();
		request_dump(r);
	endtask

	task automatic issue(x25519_op_t op, logic sw, xregid_t sa, xregid_t sb,
		xregid_t d0, xregid_t d1);
		regval_t a;
		regval_t b;
		tick();
		a = shadow[sa];
		b = shadow[sb];
		cmd_valid <= 1'b1;
		cmd_op    <= op;
		cmd_swap  <= sw;
		cmd_src_a <= sa;
		cmd_src_b <= sb;
		cmd_dst0  <= d0;
		cmd_dst1  <= d1;
		// Lands at the end of the third cycle after this one
		if (op == OP_ADDSUB)
			schedule(3'd4, d0, mod_add(a, b), d1, mod_sub(a, b));
		else if (sw)
			schedule(3'd4, d0, b, d1, a);
		else
			schedule(3'd4, d0, a, d1, b);
	endtask

	// Load two operands, run one command, read both destinations
	task automatic run_case(x25519_op_t op, logic sw, regval_t a, regval_t b, logic same_dst);
		xregid_t sa;
		xregid_t sb;
		xregid_t d0;
		xregid_t d1;
		sa = pick_reg(0, 11);
		do
			sb = pick_reg(0, 11);
		while (sb == sa);
		d0 = pick_reg(0, 11);
		d1 = same_dst ? d0 : pick_reg(0, 11);
		load(sa, a);
		load(sb, b);
		issue(op, sw, sa, sb, d0, d1);
		idle(3);
		dump(d0);
		dump(d1);
	endtask

	////////////////////////////////////////
	// Test sequence

	initial begin
		regval_t v;
		void'($urandom(32'h47286e40));
		rst        = 1'b1;
		load_valid = 1'b0;
		load_addr  = '0;
		load_data  = '0;
		dump_valid = 1'b0;
		dump_addr  = '0;
		cmd_valid  = 1'b0;
		cmd_op     = OP_ADDSUB;
		cmd_swap   = 1'b0;
		cmd_src_a  = '0;
		cmd_src_b  = '0;
		cmd_dst0   = '0;
		cmd_dst1   = '0;
		for (int i = 0; i < 8; i++)
			pend_v[i] = 1'b0;
		for (int i = 0; i < 16; i++)
			shadow[i] = '0;
		shadow[12] = 256'd1;
		shadow[14] = 256'd121665;
		shadow[15] = D2_VAL;

		idle(10);
		rst <= 1'b0;

		// Preloaded contents
		test_name = "reset_values";
		for (int i = 0; i < 16; i++)
			dump(xregid_t'(i));

		test_name = "load_readback";
		for (int i = 0; i < 12; i++) begin
			load(xregid_t'(i), rand_val());
			dump(xregid_t'(i));
		end

		// Writes to constants must vanish
		test_name = "const_protect";
		for (int i = 12; i < 16; i++) begin
			load(xregid_t'(i), rand_val());
			dump(xregid_t'(i));
		end

		test_name = "addsub";
		v = rand_val();
		run_case(OP_ADDSUB, 1'b0, v, v, 1'b0);
		run_case(OP_ADDSUB, 1'b0, rand_val(), '0, 1'b0);
		run_case(OP_ADDSUB, 1'b0, P - 256'd1, P - 256'd2, 1'b0);
		// Sum wraps past p and the difference borrows
		run_case(OP_ADDSUB, 1'b0, 256'd5, P - 256'd1, 1'b0);
		run_case(OP_ADDSUB, 1'b0, P - 256'd3, P - 256'd1, 1'b1);
		for (int i = 0; i < N_ADDSUB; i++)
			run_case(OP_ADDSUB, 1'b0, rand_val(), rand_val(), 1'($urandom_range(1, 0)));

		test_name = "swap";
		run_case(OP_SWAP, 1'b0, rand_val(), rand_val(), 1'b1);
		run_case(OP_SWAP, 1'b1, rand_val(), rand_val(), 1'b1);
		for (int i = 0; i < N_SWAP; i++)
			run_case(OP_SWAP, 1'($urandom_range(1, 0)), rand_val(), rand_val(), 1'b0);

		// Sources in 0..5 stay stable, destinations churn in 6..11
		test_name = "back_to_back";
		for (int i = 0; i < 6; i++)
			load(xregid_t'(i), rand_val());
		for (int i = 0; i < N_B2B; i++) begin
			issue((i % 2 == 0) ? OP_ADDSUB : OP_SWAP, 1'($urandom_range(1, 0)),
				pick_reg(0, 5), pick_reg(0, 5), pick_reg(6, 11), pick_reg(6, 11));
			request_dump(pick_reg(6, 11));
		end
		idle(3);
		for (int i = 6; i < 12; i++)
			dump(xregid_t'(i));

		idle(4);
		$display("Summary: %0d readback checks, %0d value errors, %0d protocol errors",
			checks, val_errors, proto_errors);
		if (val_errors == 0 && proto_errors == 0) begin
			$display("TEST PASSED");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* x25519_core.f */
hw/x25519_pkg.sv
hw/x25519_retire_if.sv
hw/x25519_regfile_bank.sv
hw/x25519_regfile.sv
hw/x25519_issue.sv
hw/x25519_addsub.sv
hw/x25519_swap.sv
hw/x25519_core.sv
tests/x25519_core_tb.sv
